// ==== logic/lcd_byte_source.sv ====
// --------------------
// Byte and dc for each step of a phase, purely combinational.
// Data steps past the drawing length are not expected.
// --------------------
`timescale 1ns/10ps

module lcd_byte_source (
	input  lcd_pkg::phase_t      phase,
	input  lcd_pkg::byte_count_t step,
	input  pet_pkg::draw_sel_t   cur_sel,
	input  pet_pkg::hunger_t     cur_level,
	output lcd_pkg::lcd_byte_t   src_byte,
	output logic                 src_dc,
	output logic                 last_step
);

	localparam int INIT_IDX_W   = $clog2(lcd_pkg::INIT_CMD_COUNT);
	localparam int SPRITE_IDX_W = $clog2(pet_pkg::SPRITE_MAX_BYTES);

	lcd_pkg::byte_count_t seg_index;
	lcd_pkg::byte_count_t seg_pos;
	logic                 bar_lit;
	lcd_pkg::lcd_byte_t   bar_byte;
	lcd_pkg::lcd_byte_t   sprite_byte;

	// --------------------
	// hunger bar
	// --------------------
	assign seg_index = step / pet_pkg::BAR_SEGMENT_PERIOD;
	assign seg_pos   = step % pet_pkg::BAR_SEGMENT_PERIOD;
	assign bar_lit   = (seg_pos < pet_pkg::BAR_SEGMENT_PERIOD - 9'd1) &&
		(seg_index < lcd_pkg::byte_count_t'(cur_level));
	assign bar_byte  = bar_lit ? pet_pkg::BAR_SEGMENT_BYTE : 8'h00;

	// --------------------
	// sprite lookup
	// --------------------
	always_comb begin
		sprite_byte = 8'h00;
		if (step < lcd_pkg::byte_count_t'(pet_pkg::SPRITE_MAX_BYTES)) begin
			case (cur_sel)
				pet_pkg::DRAW_PEAR:  sprite_byte = pet_pkg::SPRITE_BYTES[0][step[SPRITE_IDX_W-1:0]];
				pet_pkg::DRAW_HEART: sprite_byte = pet_pkg::SPRITE_BYTES[1][step[SPRITE_IDX_W-1:0]];
				pet_pkg::DRAW_CROSS: sprite_byte = pet_pkg::SPRITE_BYTES[2][step[SPRITE_IDX_W-1:0]];
				default:             sprite_byte = bar_byte;
			endcase
		end
	end

	// --------------------
	// phase mux
	// --------------------
	always_comb begin
		src_byte  = 8'h00;
		src_dc    = 1'b0;
		last_step = 1'b0;
		case (phase)
			lcd_pkg::PH_INIT: begin
				src_byte  = lcd_pkg::INIT_CMDS[step[INIT_IDX_W-1:0]];
				last_step = (step == lcd_pkg::byte_count_t'(lcd_pkg::INIT_CMD_COUNT - 1));
			end
			lcd_pkg::PH_CLEAR: begin
				src_dc    = 1'b1; // zero pixels
				last_step = (step == lcd_pkg::SCREEN_BYTES - 9'd1);
			end
			lcd_pkg::PH_SET_X: begin
				src_byte  = lcd_pkg::CMD_SET_X | {1'b0, pet_pkg::DRAW_COL[cur_sel]};
				last_step = 1'b1;
			end
			lcd_pkg::PH_SET_Y: begin
				src_byte  = lcd_pkg::CMD_SET_Y | {5'b0, pet_pkg::DRAW_BANK[cur_sel]};
				last_step = 1'b1;
			end
			lcd_pkg::PH_DATA: begin
				src_byte  = sprite_byte;
				src_dc    = 1'b1;
				last_step = (step == pet_pkg::DRAW_LEN[cur_sel] - 9'd1);
			end
			default: ;
		endcase
	end

endmodule

// ==== logic/lcd_pet_display.sv ====
// --------------------
// Pet display controller for a PCD8544 84x48 panel.
// Powers up and clears the panel by itself, then takes one draw_req at a
// time while ready is high; done pulses when the drawing is on the wire.
// --------------------
`timescale 1ns/10ps

module lcd_pet_display (
	input  logic               clock,
	input  logic               reset,
	input  logic               draw_req,
	input  pet_pkg::draw_sel_t draw_sel,
	input  pet_pkg::hunger_t   hunger,
	output logic               ready,
	output logic               done,
	output logic               lcd_sclk,
	output logic               lcd_mosi,
	output logic               lcd_sce,
	output logic               lcd_dc,
	output logic               lcd_rst
);

	logic                 tick;
	logic                 timer_run;
	logic                 byte_valid;
	logic                 byte_ready;
	lcd_pkg::lcd_byte_t   tx_byte;
	logic                 tx_dc;
	lcd_pkg::phase_t      phase;
	lcd_pkg::byte_count_t step;
	pet_pkg::draw_sel_t   cur_sel;
	pet_pkg::hunger_t     cur_level;
	lcd_pkg::lcd_byte_t   src_byte;
	logic                 src_dc;
	logic                 last_step;

	lcd_sequencer u_sequencer (
		.clock      (clock),
		.reset      (reset),
		.draw_req   (draw_req),
		.draw_sel   (draw_sel),
		.hunger     (hunger),
		.tick       (tick),
		.byte_ready (byte_ready),
		.last_step  (last_step),
		.src_byte   (src_byte),
		.src_dc     (src_dc),
		.ready      (ready),
		.done       (done),
		.lcd_rst    (lcd_rst),
		.timer_run  (timer_run),
		.phase      (phase),
		.step       (step),
		.cur_sel    (cur_sel),
		.cur_level  (cur_level),
		.byte_valid (byte_valid),
		.tx_byte    (tx_byte),
		.tx_dc      (tx_dc)
	);

	sclk_timer u_timer (
		.clock (clock),
		.reset (reset),
		.run   (timer_run),
		.tick  (tick)
	);

	lcd_byte_source u_source (
		.phase     (phase),
		.step      (step),
		.cur_sel   (cur_sel),
		.cur_level (cur_level),
		.src_byte  (src_byte),
		.src_dc    (src_dc),
		.last_step (last_step)
	);

	lcd_spi_shifter u_shifter (
		.clock      (clock),
		.reset      (reset),
		.tick       (tick),
		.byte_valid (byte_valid),
		.tx_byte    (tx_byte),
		.tx_dc      (tx_dc),
		.byte_ready (byte_ready),
		.lcd_sclk   (lcd_sclk),
		.lcd_mosi   (lcd_mosi),
		.lcd_sce    (lcd_sce),
		.lcd_dc     (lcd_dc)
	);

endmodule

// ==== logic/lcd_pkg.sv ====
// --------------------
// PCD8544 panel commands, geometry and serial timing.
// SCLK_HALF_CYCLES must be 2 or more, RST_HOLD_TICKS 2 or more.
// --------------------

package lcd_pkg;

	// --------------------
	// types
	// --------------------
	typedef logic [7:0] lcd_byte_t;   // command or pixel column byte
	typedef logic [6:0] lcd_col_t;    // x address, 0..83
	typedef logic [2:0] lcd_bank_t;   // y address, 8 pixel rows each
	typedef logic [8:0] byte_count_t; // byte index, up to 504

	// byte source selector, one per kind of byte run
	typedef enum logic [2:0] {
		PH_INIT,
		PH_CLEAR,
		PH_SET_X,
		PH_SET_Y,
		PH_DATA
	} phase_t;

	// --------------------
	// commands
	// --------------------
	localparam lcd_byte_t CMD_SET_X = 8'h80; // plus column
	localparam lcd_byte_t CMD_SET_Y = 8'h40; // plus bank

	localparam int INIT_CMD_COUNT = 4;
	localparam lcd_byte_t INIT_CMDS [0:INIT_CMD_COUNT-1] = '{
		8'h21, // extended instruction set
		8'h90, // vop, contrast
		8'h20, // back to basic set, horizontal addressing
		8'h0C  // normal display mode
	};

	// --------------------
	// geometry and timing
	// --------------------
	localparam byte_count_t SCREEN_BYTES = 9'd504; // 84 columns x 6 banks

	localparam int BITS_PER_BYTE    = 8;
	localparam int SCLK_HALF_CYCLES = 2; // clock cycles per sclk half period
	localparam int RST_HOLD_TICKS   = 8; // half periods with lcd_rst low

endpackage

// ==== logic/lcd_sequencer.sv ====
// --------------------
// Power-up, clear and drawing sequence. Byte lengths come from the
// byte source through last_step; a drawing ends once its last frame closes.
// --------------------
`timescale 1ns/10ps

module lcd_sequencer (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 draw_req,
	input  pet_pkg::draw_sel_t   draw_sel,
	input  pet_pkg::hunger_t     hunger,
	input  logic                 tick,
	input  logic                 byte_ready,
	input  logic                 last_step,
	input  lcd_pkg::lcd_byte_t   src_byte,
	input  logic                 src_dc,
	output logic                 ready,
	output logic                 done,
	output logic                 lcd_rst,
	output logic                 timer_run,
	output lcd_pkg::phase_t      phase,
	output lcd_pkg::byte_count_t step,
	output pet_pkg::draw_sel_t   cur_sel,
	output pet_pkg::hunger_t     cur_level,
	output logic                 byte_valid,
	output lcd_pkg::lcd_byte_t   tx_byte,
	output logic                 tx_dc
);

	localparam int HOLD_W = $clog2(lcd_pkg::RST_HOLD_TICKS);

	typedef enum logic [2:0] {
		PANEL_RESET,
		INIT_CMDS,
		CLEAR,
		IDLE,
		SET_X,
		SET_Y,
		SEND_DATA,
		FINISH
	} seq_state_t;

	seq_state_t        state;
	logic [HOLD_W-1:0] hold_count;
	logic              accept;
	logic              handshake;

	assign accept    = (state == IDLE) && draw_req && ready;
	assign handshake = byte_valid && byte_ready;

	// states that offer a byte to the shifter
	assign byte_valid = (state == INIT_CMDS) || (state == CLEAR) || (state == SET_X) ||
		(state == SET_Y) || (state == SEND_DATA);
	assign tx_byte    = src_byte;
	assign tx_dc      = src_dc;
	assign timer_run  = (state != IDLE); // shifter and reset hold both need ticks

	// --------------------
	// control FSM
	// --------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= PANEL_RESET;
			phase      <= lcd_pkg::PH_INIT;
			step       <= '0;
			hold_count <= '0;
			lcd_rst    <= 1'b0;
			ready      <= 1'b0;
			done       <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				PANEL_RESET: begin
					if (tick) begin
						hold_count <= hold_count + 1'b1;
						if (hold_count == HOLD_W'(lcd_pkg::RST_HOLD_TICKS - 1)) begin
							lcd_rst <= 1'b1; // release before the first command
							state   <= INIT_CMDS;
						end
					end
				end
				INIT_CMDS, CLEAR, SET_X, SET_Y, SEND_DATA: begin
					if (handshake) begin
						step <= step + 1'b1;
						if (last_step) begin
							step <= '0;
							case (state)
								INIT_CMDS: begin
									state <= CLEAR;
									phase <= lcd_pkg::PH_CLEAR;
								end
								SET_X: begin
									state <= SET_Y;
									phase <= lcd_pkg::PH_SET_Y;
								end
								SET_Y: begin
									state <= SEND_DATA;
									phase <= lcd_pkg::PH_DATA;
								end
								default: state <= FINISH; // phase kept, tells clear from draw
							endcase
						end
					end
				end
				IDLE: begin
					if (accept) begin
						ready <= 1'b0;
						state <= SET_X;
						phase <= lcd_pkg::PH_SET_X;
						step  <= '0;
					end
				end
				FINISH: begin
					if (byte_ready) begin // last frame closed
						ready <= 1'b1;
						done  <= (phase == lcd_pkg::PH_DATA);
						state <= IDLE;
					end
				end
				default: state <= PANEL_RESET;
			endcase
		end
	end

	// request payload, held for the whole drawing
	always_ff @(posedge clock) begin
		if (accept) begin
			cur_sel   <= draw_sel;
			cur_level <= (hunger > pet_pkg::BAR_MAX_LEVEL) ? pet_pkg::BAR_MAX_LEVEL : hunger;
		end
	end

endmodule

// ==== logic/lcd_spi_shifter.sv ====
// --------------------
// Write-only SPI framing, mode 0, MSB first, one byte per chip enable.
// byte_ready returns only after one tick of chip enable high.
// --------------------
`timescale 1ns/10ps

module lcd_spi_shifter (
	input  logic               clock,
	input  logic               reset,
	input  logic               tick,
	input  logic               byte_valid,
	input  lcd_pkg::lcd_byte_t tx_byte,
	input  logic               tx_dc,
	output logic               byte_ready,
	output logic               lcd_sclk,
	output logic               lcd_mosi,
	output logic               lcd_sce,
	output logic               lcd_dc
);

	localparam int BIT_W = $clog2(lcd_pkg::BITS_PER_BYTE);

	typedef enum logic [1:0] {
		SH_IDLE,
		SH_ACTIVE,
		SH_GAP
	} shift_state_t;

	shift_state_t       state;
	logic [BIT_W-1:0]   bit_count;
	lcd_pkg::lcd_byte_t shift_reg;

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= SH_IDLE;
			bit_count <= '0;
			lcd_sclk  <= 1'b0;
			lcd_sce   <= 1'b1;
		end else begin
			case (state)
				SH_IDLE: begin
					if (byte_valid) begin
						lcd_sce   <= 1'b0; // select ahead of first rising sclk
						bit_count <= '0;
						state     <= SH_ACTIVE;
					end
				end
				SH_ACTIVE: begin
					if (tick) begin
						lcd_sclk <= !lcd_sclk;
						if (lcd_sclk) begin // falling edge
							bit_count <= bit_count + 1'b1;
							if (bit_count == BIT_W'(lcd_pkg::BITS_PER_BYTE - 1)) begin
								lcd_sce <= 1'b1;
								state   <= SH_GAP;
							end
						end
					end
				end
				SH_GAP: begin
					if (tick) state <= SH_IDLE;
				end
				default: state <= SH_IDLE;
			endcase
		end
	end

	// byte and dc latched at the handshake, shifted on falling sclk
	always_ff @(posedge clock) begin
		if (state == SH_IDLE && byte_valid) begin
			shift_reg <= tx_byte;
			lcd_dc    <= tx_dc;
		end else if (state == SH_ACTIVE && tick && lcd_sclk) begin
			shift_reg <= {shift_reg[lcd_pkg::BITS_PER_BYTE-2:0], 1'b0};
		end
	end

	assign lcd_mosi   = shift_reg[lcd_pkg::BITS_PER_BYTE-1];
	assign byte_ready = (state == SH_IDLE);

endmodule

// ==== logic/pet_pkg.sv ====
// --------------------
// Drawings of the pet display and where they go on the panel.
// Sprites are one bank high; rows shorter than SPRITE_MAX_BYTES are zero padded.
// --------------------

package pet_pkg;

	typedef enum logic [1:0] {
		DRAW_PEAR,
		DRAW_HEART,
		DRAW_CROSS,
		DRAW_HUNGER_BAR
	} draw_sel_t;

	typedef logic [3:0] hunger_t;

	localparam int SPRITE_MAX_BYTES = 14;

	// --------------------
	// placement, indexed by draw_sel_t
	// --------------------
	localparam lcd_pkg::lcd_col_t DRAW_COL [0:3] = '{7'd0, 7'd56, 7'd26, 7'd9};
	localparam lcd_pkg::lcd_bank_t DRAW_BANK [0:3] = '{3'd0, 3'd0, 3'd2, 3'd0};
	localparam lcd_pkg::byte_count_t DRAW_LEN [0:3] = '{9'd7, 9'd9, 9'd8, 9'd14};

	// --------------------
	// sprite bitmaps, bit 0 is the top pixel of the bank
	// --------------------
	localparam lcd_pkg::lcd_byte_t SPRITE_BYTES [0:2][0:SPRITE_MAX_BYTES-1] = '{
		// pear
		'{8'h30, 8'h48, 8'h84, 8'h82, 8'h87, 8'h49, 8'h30,
		  8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
		// heart
		'{8'h0C, 8'h12, 8'h21, 8'h41, 8'h82, 8'h41, 8'h21,
		  8'h12, 8'h0C, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
		// cross
		'{8'h3C, 8'h24, 8'hE7, 8'h81, 8'h81, 8'hE7, 8'h24,
		  8'h3C, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}
	};

	// --------------------
	// hunger bar
	// --------------------
	// segments of 3 columns, 2 lit and 1 blank gap
	localparam hunger_t BAR_MAX_LEVEL = 4'd4;
	localparam lcd_pkg::lcd_byte_t BAR_SEGMENT_BYTE = 8'h7E;
	localparam lcd_pkg::byte_count_t BAR_SEGMENT_PERIOD = 9'd3;

endpackage

// ==== logic/sclk_timer.sv ====
// --------------------
// Half-period tick for sclk and the panel reset hold.
// Counter restarts from zero whenever run goes high.
// --------------------
`timescale 1ns/10ps

module sclk_timer (
	input  logic clock,
	input  logic reset,
	input  logic run,
	output logic tick
);

	localparam int CNT_W = $clog2(lcd_pkg::SCLK_HALF_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(lcd_pkg::SCLK_HALF_CYCLES - 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clock) begin
		if (reset || !run) begin
			count <= '0;
		end else if (count == CNT_LAST) begin
			count <= '0; // wrap
		end else begin
			count <= count + 1'b1;
		end
	end

	assign tick = run && (count == CNT_LAST);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the pet display testbench with Verilator, run it, check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

if ! verilator --binary --timing --assert -f verilog.f --top-module tb_lcd_pet_display -o tb_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "All tests passed!" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tb/lcd_pet_display_props.sv ====
// --------------------
// Handshake and SPI framing properties, bound into lcd_pet_display.
// All checks are off while reset is high.
// --------------------
`timescale 1ns/10ps

module lcd_pet_display_props (
	input logic clock,
	input logic reset,
	input logic ready,
	input logic done,
	input logic lcd_sclk,
	input logic lcd_sce,
	input logic lcd_rst
);

	done_single_pulse: assert property (@(posedge clock) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// controller is busy while a frame is open
	ready_not_in_frame: assert property (@(posedge clock) disable iff (reset) !lcd_sce |-> !ready)
		else $error("ready high while chip enable is low");

	sclk_idle_low: assert property (@(posedge clock) disable iff (reset) lcd_sce |-> !lcd_sclk)
		else $error("serial clock high while chip enable is high");

	rst_high_when_ready: assert property (@(posedge clock) disable iff (reset) ready |-> lcd_rst)
		else $error("panel in reset while ready is high");

	rst_stays_high: assert property (@(posedge clock) disable iff (reset) lcd_rst |=> lcd_rst)
		else $error("panel reset asserted again after release");

endmodule

bind lcd_pet_display lcd_pet_display_props u_props (
	.clock    (clock),
	.reset    (reset),
	.ready    (ready),
	.done     (done),
	.lcd_sclk (lcd_sclk),
	.lcd_sce  (lcd_sce),
	.lcd_rst  (lcd_rst)
);

// ==== tb/tb_lcd_pet_display.sv ====
// --------------------
// Testbench for the pet display controller. Decodes the SPI wire back into
// {dc, byte} pairs and compares them with a stream built from the panel rules.
// --------------------
`timescale 1ns/10ps

module tb_lcd_pet_display;

	localparam int CLK_NS       = 4;
	localparam int SEED         = 41828;
	localparam int HUNGER_TESTS = 20;
	// power-up, three sprites, hunger bars, one heart with busy pulses
	localparam int TOTAL_BYTES  = 508 + 30 + HUNGER_TESTS * 16 + 11;
	localparam int WATCHDOG_NS  = (TOTAL_BYTES * 20 + 200) * 2 * CLK_NS;

	localparam logic [7:0] INIT_SEQ [0:3] = '{8'h21, 8'h90, 8'h20, 8'h0C};
	localparam logic [7:0] PEAR [0:6] = '{8'h30, 8'h48, 8'h84, 8'h82, 8'h87, 8'h49, 8'h30};
	localparam logic [7:0] HEART [0:8] = '{8'h0C, 8'h12, 8'h21, 8'h41, 8'h82, 8'h41, 8'h21,
		8'h12, 8'h0C};
	localparam logic [7:0] CROSS [0:7] = '{8'h3C, 8'h24, 8'hE7, 8'h81, 8'h81, 8'hE7, 8'h24, 8'h3C};

	logic               clock;
	logic               reset;
	logic               draw_req;
	pet_pkg::draw_sel_t draw_sel;
	pet_pkg::hunger_t   hunger;
	logic               ready;
	logic               done;
	logic               lcd_sclk;
	logic               lcd_mosi;
	logic               lcd_sce;
	logic               lcd_dc;
	logic               lcd_rst;

	logic [8:0]       exp_q [$]; // {dc, byte}
	logic [8:0]       dec_q [$];
	logic [7:0]       shift_in;
	logic             prev_sclk;
	int               bit_cnt;
	int               done_count;
	int               exp_done;
	pet_pkg::hunger_t levels [HUNGER_TESTS];

	lcd_pet_display uut (
		.clock    (clock),
		.reset    (reset),
		.draw_req (draw_req),
		.draw_sel (draw_sel),
		.hunger   (hunger),
		.ready    (ready),
		.done     (done),
		.lcd_sclk (lcd_sclk),
		.lcd_mosi (lcd_mosi),
		.lcd_sce  (lcd_sce),
		.lcd_dc   (lcd_dc),
		.lcd_rst  (lcd_rst)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_NS / 2) clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] want, input logic [7:0] got);
		abort_run($sformatf("[ERROR] %0t %s expected %02h actual %02h", $time, name, want, got));
	endtask

	// --------------------
	// reference stream
	// --------------------
	function automatic void expected_stream(input bit power_up, input pet_pkg::draw_sel_t sel,
		input pet_pkg::hunger_t level);
		int lvl;
		lvl = (level > 4'd4) ? 4 : int'(level); // bar clamps at 4 segments
		if (power_up) begin
			for (int i = 0; i < 4; i++) exp_q.push_back({1'b0, INIT_SEQ[i]});
			for (int i = 0; i < 504; i++) exp_q.push_back({1'b1, 8'h00}); // 84 x 6 banks
		end else begin
			case (sel)
				pet_pkg::DRAW_PEAR: begin
					exp_q.push_back({1'b0, 8'h80 + 8'd0});
					exp_q.push_back({1'b0, 8'h40 + 8'd0});
					for (int i = 0; i < 7; i++) exp_q.push_back({1'b1, PEAR[i]});
				end
				pet_pkg::DRAW_HEART: begin
					exp_q.push_back({1'b0, 8'h80 + 8'd56});
					exp_q.push_back({1'b0, 8'h40 + 8'd0});
					for (int i = 0; i < 9; i++) exp_q.push_back({1'b1, HEART[i]});
				end
				pet_pkg::DRAW_CROSS: begin
					exp_q.push_back({1'b0, 8'h80 + 8'd26});
					exp_q.push_back({1'b0, 8'h40 + 8'd2});
					for (int i = 0; i < 8; i++) exp_q.push_back({1'b1, CROSS[i]});
				end
				default: begin
					exp_q.push_back({1'b0, 8'h80 + 8'd9});
					exp_q.push_back({1'b0, 8'h40 + 8'd0});
					for (int k = 0; k < 14; k++)
						exp_q.push_back({1'b1, ((k % 3 < 2) && (k / 3 < lvl)) ? 8'h7E : 8'h00});
				end
			endcase
		end
	endfunction

	// --------------------
	// SPI decoder and compare
	// --------------------
	always @(posedge clock) begin
		if (reset || lcd_sce) begin
			assert (reset || bit_cnt == 0) else abort_run("chip enable rose in the middle of a byte");
			bit_cnt = 0;
		end else if (lcd_sclk && !prev_sclk) begin
			assert (lcd_rst) else abort_run("serial clock ran while the panel was in reset");
			shift_in = {shift_in[6:0], lcd_mosi}; // msb first
			bit_cnt  = bit_cnt + 1;
			if (bit_cnt == 8) begin
				dec_q.push_back({lcd_dc, shift_in});
				bit_cnt = 0;
			end
		end
		prev_sclk = lcd_sclk;
	end

	always @(posedge clock) begin
		logic [8:0] got;
		logic [8:0] want;
		if (dec_q.size() > 0) begin
			got = dec_q.pop_front();
			assert (exp_q.size() > 0)
				else abort_run($sformatf("unexpected byte %02h sent to the panel", got[7:0]));
			want = exp_q.pop_front();
			assert (got[7:0] == want[7:0]) else report_mismatch("lcd_mosi byte", want[7:0], got[7:0]);
			assert (got[8] == want[8]) else report_mismatch("lcd_dc", {7'b0, want[8]}, {7'b0, got[8]});
		end
	end

	always @(posedge clock) begin
		if (!reset && done) done_count = done_count + 1;
	end

	// --------------------
	// stimulus
	// --------------------
	task automatic wait_ready();
		do @(posedge clock); while (!ready);
	endtask

	task automatic request_drawing(input pet_pkg::draw_sel_t sel, input pet_pkg::hunger_t level,
		input bit pulse_while_busy);
		wait_ready();
		expected_stream(1'b0, sel, level);
		exp_done = exp_done + 1;
		draw_req <= 1'b1;
		draw_sel <= sel;
		hunger   <= level;
		@(posedge clock); // accepted here
		draw_req <= 1'b0;
		if (pulse_while_busy) begin
			repeat (3) begin
				repeat (4) @(posedge clock);
				assert (!ready) else abort_run("ready high during a drawing");
				draw_req <= 1'b1;
				draw_sel <= pet_pkg::DRAW_CROSS;
				hunger   <= 4'd3;
				@(posedge clock);
				draw_req <= 1'b0;
			end
		end
		do @(posedge clock); while (!done);
		assert (ready) else abort_run("ready did not rise together with done");
		@(posedge clock);
		assert (done_count == exp_done)
			else abort_run($sformatf("saw %0d done pulses, wanted %0d", done_count, exp_done));
		assert (exp_q.size() == 0) else abort_run("drawing ended before all its bytes were sent");
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("watchdog expired with %0d bytes still expected", exp_q.size()));
	end

	initial begin
		void'($urandom(SEED));
		reset      = 1'b1;
		draw_req   = 1'b0;
		draw_sel   = pet_pkg::DRAW_PEAR;
		hunger     = 4'd0;
		done_count = 0;
		exp_done   = 0;
		bit_cnt    = 0;
		prev_sclk  = 1'b0;
		shift_in   = 8'h00;
		expected_stream(1'b1, pet_pkg::DRAW_PEAR, 4'd0);
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		assert (!lcd_rst && lcd_sce) else abort_run("panel not held in reset after power-up");
		do @(posedge clock); while (!lcd_rst);
		assert (dec_q.size() == 0 && exp_q.size() == 508)
			else abort_run("bytes sent before the panel reset was released");
		wait_ready();
		@(posedge clock);
		assert (exp_q.size() == 0) else abort_run("ready rose before the screen was cleared");
		assert (done_count == 0) else abort_run("done pulsed after the power-up clear");

		request_drawing(pet_pkg::DRAW_PEAR, 4'd0, 1'b0);
		request_drawing(pet_pkg::DRAW_HEART, 4'd0, 1'b0);
		request_drawing(pet_pkg::DRAW_CROSS, 4'd0, 1'b0);

		levels[0] = 4'd0;
		levels[1] = 4'd4;
		levels[2] = 4'd15;
		for (int i = 3; i < HUNGER_TESTS; i++) levels[i] = pet_pkg::hunger_t'($urandom_range(15, 0));
		for (int i = 0; i < HUNGER_TESTS; i++) request_drawing(pet_pkg::DRAW_HUNGER_BAR, levels[i], 1'b0);

		request_drawing(pet_pkg::DRAW_HEART, 4'd0, 1'b1);
		repeat (200) @(posedge clock); // an ignored request would show up here
		assert (exp_q.size() == 0 && dec_q.size() == 0) else abort_run("byte stream did not drain");
		assert (done_count == exp_done) else abort_run("done count differs from accepted requests");
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/lcd_pkg.sv
logic/pet_pkg.sv
logic/sclk_timer.sv
logic/lcd_byte_source.sv
logic/lcd_spi_shifter.sv
logic/lcd_sequencer.sv
logic/lcd_pet_display.sv
tb/lcd_pet_display_props.sv
tb/tb_lcd_pet_display.sv
